// File: hw/csr_fields_pkg.sv
/*
 * CSR map of the trap unit.
 * Machine trap CSR addresses and mstatus field positions.
 */
`default_nettype none

package csr_fields_pkg;

    typedef logic [11:0] csr_addr_t;

    // machine trap setup and handling
    localparam csr_addr_t MSTATUS = 12'h300;
    localparam csr_addr_t MIE     = 12'h304;
    localparam csr_addr_t MTVEC   = 12'h305;
    localparam csr_addr_t MEPC    = 12'h341;
    localparam csr_addr_t MCAUSE  = 12'h342;
    localparam csr_addr_t MTVAL   = 12'h343;
    localparam csr_addr_t MIP     = 12'h344;

    // mstatus fields kept by this unit
    localparam int MIE_BIT  = 3;
    localparam int MPIE_BIT = 7;
    localparam int MPP_HI   = 12;
    localparam int MPP_LO   = 11;

    localparam logic [1:0] MPP_M = 2'b11;   // machine mode

endpackage

`default_nettype wire

// File: hw/irq_pending_slot.sv
/*
 * Pending slot for one local interrupt line.
 * Runs the four-phase req/ack handshake with its device and keeps the mip bit.
 */
`timescale 1ns/1ps
`default_nettype none

module irq_pending_slot (
    input  wire  CLK,
    input  wire  rst_n,
    input  wire  irq_req,
    output logic irq_ack,
    input  wire  mip_clear,
    output logic pending
);

    typedef enum logic {
        st_idle,
        st_acked
    } hs_state_e;

    hs_state_e state;
    logic      capture;

    // new request seen while ack is still low
    assign capture = irq_req && (state == st_idle);

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:  if (irq_req) state <= st_acked;
                st_acked: if (!irq_req) state <= st_idle;  // device released req
                default:  state <= st_idle;
            endcase
        end
    end

    assign irq_ack = (state == st_acked);

    // a capture in the same cycle as a clear keeps the bit set
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (capture) begin
            pending <= 1'b1;
        end else if (mip_clear) begin
            pending <= 1'b0;
        end
    end

    a_ack_after_req: assert property (@(posedge CLK) disable iff (!rst_n)
        $rose(irq_ack) |-> $past(irq_req));

endmodule

`default_nettype wire

// File: hw/machine_trap_csrs.sv
/*
 * Machine trap CSR file.
 * Serves software CSR reads and writes, applies trap and mret updates
 * from the handler, and turns MIP writes into per-line clear pulses.
 */
`timescale 1ns/1ps
`default_nettype none

module machine_trap_csrs #(
    parameter int NUM_IRQ = 4
) (
    input  wire                            CLK,
    input  wire                            rst_n,
    input  wire                            csr_we,
    input  wire csr_fields_pkg::csr_addr_t csr_addr,
    input  wire trap_cause_pkg::xlen_t     csr_wdata,
    output trap_cause_pkg::xlen_t          csr_rdata,
    input  wire [NUM_IRQ-1:0]              irq_pending,
    output logic [NUM_IRQ-1:0]             mip_clear,
    input  wire                            inject_trap,
    input  wire                            inject_mret,
    input  wire trap_cause_pkg::xlen_t     next_mstatus,
    input  wire trap_cause_pkg::xlen_t     next_mcause,
    input  wire trap_cause_pkg::xlen_t     next_mepc,
    input  wire trap_cause_pkg::xlen_t     next_mtval,
    output trap_cause_pkg::xlen_t          cur_mstatus,
    output logic [NUM_IRQ-1:0]             cur_mie,
    output trap_cause_pkg::xlen_t          trap_pc
);

    localparam int IRQ_LO = trap_cause_pkg::LOCAL_IRQ_BASE;

    logic                  mst_mie;
    logic                  mst_mpie;
    logic [NUM_IRQ-1:0]    mie_q;
    trap_cause_pkg::xlen_t mtvec_q;
    trap_cause_pkg::xlen_t mepc_q;
    trap_cause_pkg::xlen_t mcause_q;
    trap_cause_pkg::xlen_t mtval_q;
    trap_cause_pkg::xlen_t mie_word;
    trap_cause_pkg::xlen_t mip_word;

    logic wr_mstatus;
    logic wr_mie;
    logic wr_mtvec;
    logic wr_mepc;
    logic wr_mcause;
    logic wr_mtval;
    logic wr_mip;

    assign wr_mstatus = csr_we && (csr_addr == csr_fields_pkg::MSTATUS);
    assign wr_mie     = csr_we && (csr_addr == csr_fields_pkg::MIE);
    assign wr_mtvec   = csr_we && (csr_addr == csr_fields_pkg::MTVEC);
    assign wr_mepc    = csr_we && (csr_addr == csr_fields_pkg::MEPC);
    assign wr_mcause  = csr_we && (csr_addr == csr_fields_pkg::MCAUSE);
    assign wr_mtval   = csr_we && (csr_addr == csr_fields_pkg::MTVAL);
    assign wr_mip     = csr_we && (csr_addr == csr_fields_pkg::MIP);

    // writing a local mip bit to 0 clears that line
    assign mip_clear = wr_mip ? ~csr_wdata[IRQ_LO +: NUM_IRQ] : '0;

    // handler updates of mstatus take precedence over software writes
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            mst_mie  <= 1'b0;
            mst_mpie <= 1'b0;
        end else if (inject_trap || inject_mret) begin
            mst_mie  <= next_mstatus[csr_fields_pkg::MIE_BIT];
            mst_mpie <= next_mstatus[csr_fields_pkg::MPIE_BIT];
        end else if (wr_mstatus) begin
            mst_mie  <= csr_wdata[csr_fields_pkg::MIE_BIT];
            mst_mpie <= csr_wdata[csr_fields_pkg::MPIE_BIT];
        end
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            mie_q    <= '0;
            mtvec_q  <= '0;
            mepc_q   <= '0;
            mcause_q <= '0;
            mtval_q  <= '0;
        end else begin
            if (wr_mie)
                mie_q <= csr_wdata[IRQ_LO +: NUM_IRQ];
            if (wr_mtvec)
                mtvec_q <= {csr_wdata[31:2], 2'b00};   // direct mode only
            if (inject_trap) begin
                mepc_q   <= next_mepc;
                mcause_q <= next_mcause;
                mtval_q  <= next_mtval;
            end else begin
                if (wr_mepc)
                    mepc_q <= csr_wdata;
                if (wr_mcause)
                    mcause_q <= csr_wdata;
                if (wr_mtval)
                    mtval_q <= csr_wdata;
            end
        end
    end

    always_comb begin
        cur_mstatus = '0;
        cur_mstatus[csr_fields_pkg::MIE_BIT]  = mst_mie;
        cur_mstatus[csr_fields_pkg::MPIE_BIT] = mst_mpie;
        // the hart only runs in M-mode, so MPP always reads 11
        cur_mstatus[csr_fields_pkg::MPP_HI:csr_fields_pkg::MPP_LO] = csr_fields_pkg::MPP_M;
        mie_word = '0;
        mie_word[IRQ_LO +: NUM_IRQ] = mie_q;
        mip_word = '0;
        mip_word[IRQ_LO +: NUM_IRQ] = irq_pending;   // live view of the slots
    end

    assign cur_mie = mie_q;
    assign trap_pc = mtvec_q;

    always_comb begin
        case (csr_addr)
            csr_fields_pkg::MSTATUS: csr_rdata = cur_mstatus;
            csr_fields_pkg::MIE:     csr_rdata = mie_word;
            csr_fields_pkg::MTVEC:   csr_rdata = mtvec_q;
            csr_fields_pkg::MEPC:    csr_rdata = mepc_q;
            csr_fields_pkg::MCAUSE:  csr_rdata = mcause_q;
            csr_fields_pkg::MTVAL:   csr_rdata = mtval_q;
            csr_fields_pkg::MIP:     csr_rdata = mip_word;
            default:                 csr_rdata = '0;
        endcase
    end

    // the handler never retires a trap and an mret in one cycle
    a_one_inject: assert property (@(posedge CLK) disable iff (!rst_n)
        !(inject_trap && inject_mret));

endmodule

`default_nettype wire

// File: hw/trap_cause_pkg.sv
/*
 * Trap cause definitions for the machine-mode trap unit.
 * Word and cause widths, exception codes and the local interrupt base.
 */
`default_nettype none

package trap_cause_pkg;

    typedef logic [31:0] xlen_t;    // data and address word
    typedef logic [30:0] cause_t;   // mcause code, interrupt flag excluded

    // standard machine exception codes
    typedef enum logic [30:0] {
        insn_mal    = 31'd0,
        insn_access = 31'd1,
        illegal_insn = 31'd2,
        breakpoint  = 31'd3,
        l_addr_mal  = 31'd4,
        l_fault     = 31'd5,
        s_addr_mal  = 31'd6,
        s_fault     = 31'd7,
        env_call_m  = 31'd11        // only M-mode ecall exists here
    } ex_code_e;

    // first platform-defined interrupt, also the first local mip/mie bit
    localparam int LOCAL_IRQ_BASE = 16;

    localparam int INT_BIT = 31;    // interrupt flag in mcause

endpackage

`default_nettype wire

// File: hw/trap_handler.sv
/*
 * Trap handler.
 * Picks the winning exception or local interrupt by fixed priority and
 * computes the next mstatus, mcause, mepc and mtval.
 */
`timescale 1ns/1ps
`default_nettype none

module trap_handler #(
    parameter int NUM_IRQ = 4
) (
    input  wire                        illegal_insn,
    input  wire                        breakpoint,
    input  wire                        ecall,
    input  wire                        mal_insn,
    input  wire                        fault_insn,
    input  wire                        mal_l,
    input  wire                        fault_l,
    input  wire                        mal_s,
    input  wire                        fault_s,
    input  wire                        mret,
    input  wire trap_cause_pkg::xlen_t epc,
    input  wire trap_cause_pkg::xlen_t bad_addr,
    input  wire [NUM_IRQ-1:0]          irq_pending,
    input  wire trap_cause_pkg::xlen_t cur_mstatus,
    input  wire [NUM_IRQ-1:0]          cur_mie,
    output logic                       trap_taken,
    output logic                       inject_trap,
    output logic                       inject_mret,
    output trap_cause_pkg::xlen_t      next_mstatus,
    output trap_cause_pkg::xlen_t      next_mcause,
    output trap_cause_pkg::xlen_t      next_mepc,
    output trap_cause_pkg::xlen_t      next_mtval
);

    localparam int IRQ_LO = trap_cause_pkg::LOCAL_IRQ_BASE;

    trap_cause_pkg::ex_code_e ex_src;
    trap_cause_pkg::cause_t   int_src;
    logic                     exception;
    logic [NUM_IRQ-1:0]       irq_hit;
    logic                     irq_fire;

    // exception source, highest priority first
    always_comb begin
        exception = 1'b1;
        ex_src    = trap_cause_pkg::insn_mal;
        if (breakpoint)
            ex_src = trap_cause_pkg::breakpoint;
        else if (fault_insn)
            ex_src = trap_cause_pkg::insn_access;
        else if (illegal_insn)
            ex_src = trap_cause_pkg::illegal_insn;
        else if (mal_insn)
            ex_src = trap_cause_pkg::insn_mal;
        else if (ecall)
            ex_src = trap_cause_pkg::env_call_m;
        else if (mal_s)
            ex_src = trap_cause_pkg::s_addr_mal;
        else if (mal_l)
            ex_src = trap_cause_pkg::l_addr_mal;
        else if (fault_s)
            ex_src = trap_cause_pkg::s_fault;
        else if (fault_l)
            ex_src = trap_cause_pkg::l_fault;
        else
            exception = 1'b0;
    end

    assign irq_hit  = irq_pending & cur_mie;
    assign irq_fire = cur_mstatus[csr_fields_pkg::MIE_BIT] && (|irq_hit);

    // lowest enabled line wins, so scan downwards
    always_comb begin
        int_src = trap_cause_pkg::cause_t'(IRQ_LO);
        for (int i = NUM_IRQ - 1; i >= 0; i--) begin
            if (irq_hit[i])
                int_src = trap_cause_pkg::cause_t'(IRQ_LO + i);
        end
    end

    assign trap_taken  = exception || irq_fire;   // exception beats interrupt
    assign inject_trap = trap_taken;
    assign inject_mret = mret && !trap_taken;

    assign next_mcause = {!exception, exception ? trap_cause_pkg::cause_t'(ex_src) : int_src};
    assign next_mepc   = epc;
    // ecall and interrupts leave no faulting address
    assign next_mtval  = (exception && ex_src != trap_cause_pkg::env_call_m) ? bad_addr : '0;

    always_comb begin
        next_mstatus = cur_mstatus;
        if (trap_taken) begin
            next_mstatus[csr_fields_pkg::MPIE_BIT] = cur_mstatus[csr_fields_pkg::MIE_BIT];
            next_mstatus[csr_fields_pkg::MIE_BIT]  = 1'b0;
            next_mstatus[csr_fields_pkg::MPP_HI:csr_fields_pkg::MPP_LO] = csr_fields_pkg::MPP_M;
        end else if (mret) begin
            next_mstatus[csr_fields_pkg::MIE_BIT]  = cur_mstatus[csr_fields_pkg::MPIE_BIT];
            next_mstatus[csr_fields_pkg::MPIE_BIT] = 1'b1;
        end
    end

    // interrupt codes must name a real line, exception codes a known cause
    always_comb begin
        if (trap_taken) begin
            a_legal_cause: assert final (next_mcause[trap_cause_pkg::INT_BIT]
                ? (next_mcause[30:0] >= IRQ_LO && next_mcause[30:0] < IRQ_LO + NUM_IRQ)
                : (next_mcause[30:0] inside {[31'd0:31'd7], 31'd11}));
        end
    end

endmodule

`default_nettype wire

// File: hw/trap_unit_top.sv
/*
 * Machine-mode trap unit.
 * CSR file, one pending slot per local interrupt line, and the trap handler.
 */
`timescale 1ns/1ps
`default_nettype none

module trap_unit_top #(
    parameter int NUM_IRQ = 4
) (
    input  wire                            CLK,
    input  wire                            rst_n,
    input  wire                            illegal_insn,
    input  wire                            breakpoint,
    input  wire                            ecall,
    input  wire                            mal_insn,
    input  wire                            fault_insn,
    input  wire                            mal_l,
    input  wire                            fault_l,
    input  wire                            mal_s,
    input  wire                            fault_s,
    input  wire                            mret,
    input  wire trap_cause_pkg::xlen_t     epc,
    input  wire trap_cause_pkg::xlen_t     bad_addr,
    output logic                           trap_taken,
    output trap_cause_pkg::xlen_t          trap_pc,
    input  wire                            csr_we,
    input  wire csr_fields_pkg::csr_addr_t csr_addr,
    input  wire trap_cause_pkg::xlen_t     csr_wdata,
    output trap_cause_pkg::xlen_t          csr_rdata,
    input  wire [NUM_IRQ-1:0]              irq_req,
    output logic [NUM_IRQ-1:0]             irq_ack
);

    logic [NUM_IRQ-1:0]    mip_clear;
    logic [NUM_IRQ-1:0]    irq_pending;
    logic [NUM_IRQ-1:0]    cur_mie;
    logic                  inject_trap;
    logic                  inject_mret;
    trap_cause_pkg::xlen_t cur_mstatus;
    trap_cause_pkg::xlen_t next_mstatus;
    trap_cause_pkg::xlen_t next_mcause;
    trap_cause_pkg::xlen_t next_mepc;
    trap_cause_pkg::xlen_t next_mtval;

    machine_trap_csrs #(
        .NUM_IRQ(NUM_IRQ)
    ) csrs0 (
        .CLK(CLK),
        .rst_n(rst_n),
        .csr_we(csr_we),
        .csr_addr(csr_addr),
        .csr_wdata(csr_wdata),
        .csr_rdata(csr_rdata),
        .irq_pending(irq_pending),
        .mip_clear(mip_clear),
        .inject_trap(inject_trap),
        .inject_mret(inject_mret),
        .next_mstatus(next_mstatus),
        .next_mcause(next_mcause),
        .next_mepc(next_mepc),
        .next_mtval(next_mtval),
        .cur_mstatus(cur_mstatus),
        .cur_mie(cur_mie),
        .trap_pc(trap_pc)
    );

    // one slot per local line
    for (genvar i = 0; i < NUM_IRQ; i++) begin : g_slot
        irq_pending_slot slot0 (
            .CLK(CLK),
            .rst_n(rst_n),
            .irq_req(irq_req[i]),
            .irq_ack(irq_ack[i]),
            .mip_clear(mip_clear[i]),
            .pending(irq_pending[i])
        );
    end

    trap_handler #(
        .NUM_IRQ(NUM_IRQ)
    ) handler0 (
        .illegal_insn(illegal_insn),
        .breakpoint(breakpoint),
        .ecall(ecall),
        .mal_insn(mal_insn),
        .fault_insn(fault_insn),
        .mal_l(mal_l),
        .fault_l(fault_l),
        .mal_s(mal_s),
        .fault_s(fault_s),
        .mret(mret),
        .epc(epc),
        .bad_addr(bad_addr),
        .irq_pending(irq_pending),
        .cur_mstatus(cur_mstatus),
        .cur_mie(cur_mie),
        .trap_taken(trap_taken),
        .inject_trap(inject_trap),
        .inject_mret(inject_mret),
        .next_mstatus(next_mstatus),
        .next_mcause(next_mcause),
        .next_mepc(next_mepc),
        .next_mtval(next_mtval)
    );

endmodule

`default_nettype wire

// File: sim.f
hw/trap_cause_pkg.sv
hw/csr_fields_pkg.sv
hw/irq_pending_slot.sv
hw/machine_trap_csrs.sv
hw/trap_handler.sv
hw/trap_unit_top.sv
verif/trap_unit_tb.sv

// File: verif/trap_unit_tb.sv
/*
 * Testbench for the machine-mode trap unit.
 * Device models on the local lines, a reference trap model and directed
 * plus LFSR-driven checks of priority, CSR updates and interrupt masking.
 */
`timescale 1ns/1ps
`default_nettype none

module trap_unit_tb;

    localparam int NUM_IRQ   = 4;
    localparam int ACK_LIMIT = 20;    // cycles a device waits on its slot

    logic CLK;
    logic rst_n;
    logic illegal_insn;
    logic breakpoint;
    logic ecall;
    logic mal_insn;
    logic fault_insn;
    logic mal_l;
    logic fault_l;
    logic mal_s;
    logic fault_s;
    logic mret;
    trap_cause_pkg::xlen_t epc;
    trap_cause_pkg::xlen_t bad_addr;
    trap_cause_pkg::xlen_t trap_pc;
    trap_cause_pkg::xlen_t csr_wdata;
    trap_cause_pkg::xlen_t csr_rdata;
    logic trap_taken;
    logic csr_we;
    csr_fields_pkg::csr_addr_t csr_addr;
    logic [NUM_IRQ-1:0] irq_req;
    logic [NUM_IRQ-1:0] irq_ack;

    int errors;
    int checks;
    int tests;
    int err_mark;
    logic [31:0] lfsr;
    // what the CSRs should hold, kept from the trap rules
    logic [NUM_IRQ-1:0] m_pend;
    logic [NUM_IRQ-1:0] m_mie;
    trap_cause_pkg::xlen_t m_mstatus;
    trap_cause_pkg::xlen_t m_mepc;
    trap_cause_pkg::xlen_t m_mcause;
    trap_cause_pkg::xlen_t m_mtval;
    trap_cause_pkg::xlen_t rd;
    trap_cause_pkg::xlen_t tpc;
    trap_cause_pkg::xlen_t taddr;
    logic [8:0] tf;
    logic [NUM_IRQ-1:0] mask;
    int line;
    csr_fields_pkg::csr_addr_t zero_regs [6];

    trap_unit_top #(
        .NUM_IRQ(NUM_IRQ)
    ) dut0 (
        .CLK(CLK), .rst_n(rst_n),
        .illegal_insn(illegal_insn), .breakpoint(breakpoint), .ecall(ecall),
        .mal_insn(mal_insn), .fault_insn(fault_insn), .mal_l(mal_l),
        .fault_l(fault_l), .mal_s(mal_s), .fault_s(fault_s), .mret(mret),
        .epc(epc), .bad_addr(bad_addr), .trap_taken(trap_taken), .trap_pc(trap_pc),
        .csr_we(csr_we), .csr_addr(csr_addr), .csr_wdata(csr_wdata),
        .csr_rdata(csr_rdata), .irq_req(irq_req), .irq_ack(irq_ack)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic trap_cause_pkg::xlen_t rand_bits(input int n);
        trap_cause_pkg::xlen_t v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // flags are indexed in priority order, bit 0 highest
    function automatic void expected_trap(
        input  logic [8:0]            flags,
        input  logic [NUM_IRQ-1:0]    pend,
        input  logic [NUM_IRQ-1:0]    en,
        input  trap_cause_pkg::xlen_t mstatus,
        input  trap_cause_pkg::xlen_t addr,
        output logic                  taken,
        output trap_cause_pkg::xlen_t mcause,
        output trap_cause_pkg::xlen_t mtval
    );
        int codes [9] = '{3, 1, 2, 0, 11, 6, 4, 7, 5};
        taken  = 1'b0;
        mcause = '0;
        mtval  = '0;
        for (int k = 8; k >= 0; k--) begin
            if (flags[k]) begin
                taken  = 1'b1;
                mcause = codes[k];
                mtval  = (k == 4) ? '0 : addr;   // ecall has no bad address
            end
        end
        if (!taken && mstatus[3]) begin
            for (int k = NUM_IRQ - 1; k >= 0; k--) begin
                if (pend[k] && en[k]) begin
                    taken  = 1'b1;
                    mcause = {1'b1, 31'(trap_cause_pkg::LOCAL_IRQ_BASE + k)};
                end
            end
        end
    endfunction

    task check_bit(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at time %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task check_word(input string what, input trap_cause_pkg::xlen_t got,
                    input trap_cause_pkg::xlen_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task check_cause(input string what, input trap_cause_pkg::cause_t got,
                     input trap_cause_pkg::cause_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task abort_run(input string what);
        $display("%s at time %0t", what, $time);
        $display("TESTS FAILED");
        $finish;
    endtask

    task finish_test(input string name);
        tests++;
        $display("test %-10s %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    task tick();
        @(posedge CLK);
        #1;
    endtask

    task drive_flags(input logic [8:0] f);
        breakpoint   = f[0];
        fault_insn   = f[1];
        illegal_insn = f[2];
        mal_insn     = f[3];
        ecall        = f[4];
        mal_s        = f[5];
        mal_l        = f[6];
        fault_s      = f[7];
        fault_l      = f[8];
    endtask

    task csr_write(input csr_fields_pkg::csr_addr_t a, input trap_cause_pkg::xlen_t d);
        tick();
        csr_we    = 1'b1;
        csr_addr  = a;
        csr_wdata = d;
        tick();
        csr_we = 1'b0;
    endtask

    task csr_read(input csr_fields_pkg::csr_addr_t a, output trap_cause_pkg::xlen_t d);
        tick();
        csr_addr = a;
        #1 d = csr_rdata;    // read port is combinational
    endtask

    // call at a drive point; checks trap_taken now and the CSRs after the edge
    task automatic apply_and_check(input logic [8:0] f, input trap_cause_pkg::xlen_t pc,
                                   input trap_cause_pkg::xlen_t addr);
        logic taken;
        trap_cause_pkg::xlen_t cause;
        trap_cause_pkg::xlen_t tval;
        trap_cause_pkg::xlen_t v;
        drive_flags(f);
        epc      = pc;
        bad_addr = addr;
        #1;
        expected_trap(f, m_pend, m_mie, m_mstatus, addr, taken, cause, tval);
        check_bit("trap_taken", trap_taken, taken);
        if (taken) begin
            m_mstatus[7]     = m_mstatus[3];
            m_mstatus[3]     = 1'b0;
            m_mstatus[12:11] = 2'b11;
            m_mepc   = pc;
            m_mcause = cause;
            m_mtval  = tval;
        end
        tick();
        drive_flags('0);
        csr_read(csr_fields_pkg::MCAUSE, v);
        check_bit("mcause interrupt", v[31], m_mcause[31]);
        check_cause("mcause code", v[30:0], m_mcause[30:0]);
        csr_read(csr_fields_pkg::MEPC, v);
        check_word("mepc", v, m_mepc);
        csr_read(csr_fields_pkg::MTVAL, v);
        check_word("mtval", v, m_mtval);
        csr_read(csr_fields_pkg::MSTATUS, v);
        check_word("mstatus", v, m_mstatus);
    endtask

    // no trap may fire for n cycles with no exception present
    task automatic idle_check(input int n);
        logic taken;
        trap_cause_pkg::xlen_t cause;
        trap_cause_pkg::xlen_t tval;
        repeat (n) begin
            tick();
            #1;
            expected_trap('0, m_pend, m_mie, m_mstatus, '0, taken, cause, tval);
            check_bit("trap_taken while masked", trap_taken, taken);
        end
    endtask

    // one four-phase cycle as seen from the device
    task automatic device_cycle(input int idx, input int delay);
        int n;
        repeat (delay) tick();
        irq_req[idx] = 1'b1;
        tick();
        n = 1;
        while (!irq_ack[idx]) begin
            if (n >= ACK_LIMIT)
                abort_run($sformatf("no ack on line %0d", idx));
            tick();
            n++;
        end
        check_bit("ack one cycle after req", n == 1, 1'b1);
        irq_req[idx] = 1'b0;
        n = 0;
        while (irq_ack[idx]) begin
            if (n >= ACK_LIMIT)
                abort_run($sformatf("ack stuck high on line %0d", idx));
            tick();
            n++;
        end
    endtask

    initial begin
        errors = 0;
        checks = 0;
        tests = 0;
        err_mark = 0;
        lfsr = 32'd71061;
        rst_n = 1'b0;
        drive_flags('0);
        mret = 1'b0;
        epc = '0;
        bad_addr = '0;
        csr_we = 1'b0;
        csr_addr = '0;
        csr_wdata = '0;
        irq_req = '0;
        m_pend = '0;
        m_mie = '0;
        m_mstatus = 32'h0000_1800;    // MPP = M after reset
        m_mepc = '0;
        m_mcause = '0;
        m_mtval = '0;
        zero_regs = '{csr_fields_pkg::MIE, csr_fields_pkg::MTVEC, csr_fields_pkg::MEPC,
                      csr_fields_pkg::MCAUSE, csr_fields_pkg::MTVAL, csr_fields_pkg::MIP};
        repeat (4) @(posedge CLK);
        #1 rst_n = 1'b1;

        csr_read(csr_fields_pkg::MSTATUS, rd);
        check_word("mstatus after reset", rd, m_mstatus);
        for (int k = 0; k < 6; k++) begin
            csr_read(zero_regs[k], rd);
            check_word($sformatf("csr %h after reset", zero_regs[k]), rd, '0);
        end
        check_bit("irq_ack after reset", |irq_ack, 1'b0);
        check_bit("trap_taken after reset", trap_taken, 1'b0);
        finish_test("reset");

        // sparse flag sets so that each priority level gets hit
        for (int k = 0; k < 24; k++) begin
            tf    = 9'(rand_bits(9) & rand_bits(9));
            tpc   = rand_bits(32);
            taddr = rand_bits(32);
            tick();
            apply_and_check(tf, tpc, taddr);
        end
        finish_test("priority");

        tpc = rand_bits(30) << 2;
        csr_write(csr_fields_pkg::MTVEC, tpc);
        check_word("trap_pc", trap_pc, tpc);
        csr_write(csr_fields_pkg::MSTATUS, 32'h0000_1808);
        m_mstatus = 32'h0000_1808;
        tick();
        apply_and_check(9'b1 << 4, rand_bits(32), rand_bits(32));   // ecall
        tick();
        mret = 1'b1;
        #1 check_bit("trap_taken on mret", trap_taken, 1'b0);
        tick();
        mret = 1'b0;
        m_mstatus[3] = m_mstatus[7];
        m_mstatus[7] = 1'b1;
        csr_read(csr_fields_pkg::MSTATUS, rd);
        check_word("mstatus after mret", rd, m_mstatus);
        finish_test("mstatus");

        csr_write(csr_fields_pkg::MSTATUS, 32'h0000_1800);
        m_mstatus = 32'h0000_1800;
        csr_write(csr_fields_pkg::MIE, '0);
        m_mie = '0;
        fork
            device_cycle(0, rand_bits(3));
            device_cycle(1, rand_bits(3));
            device_cycle(2, rand_bits(3));
            device_cycle(3, rand_bits(3));
        join
        m_pend = '1;
        csr_read(csr_fields_pkg::MIP, rd);
        check_word("mip after handshakes", rd, 32'(m_pend) << 16);
        mask = NUM_IRQ'(rand_bits(NUM_IRQ));
        // at least two enabled lines so that the lower one has to win
        if ($countones(mask) < 2)
            mask = mask | 4'b1100;
        csr_write(csr_fields_pkg::MIE, 32'(mask) << 16);
        m_mie = mask;
        csr_write(csr_fields_pkg::MSTATUS, 32'h0000_1808);
        m_mstatus = 32'h0000_1808;
        apply_and_check('0, rand_bits(32), rand_bits(32));   // interrupt only
        csr_write(csr_fields_pkg::MSTATUS, 32'h0000_1808);
        m_mstatus = 32'h0000_1808;
        tf = 9'b1 << (rand_bits(4) % 9);
        apply_and_check(tf, rand_bits(32), rand_bits(32));  // exception beats irq
        finish_test("interrupt");

        csr_write(csr_fields_pkg::MIE, 32'h000F_0000);
        m_mie = '1;
        idle_check(3);                                      // MIE is 0 here
        csr_write(csr_fields_pkg::MIE, '0);
        m_mie = '0;
        csr_write(csr_fields_pkg::MSTATUS, 32'h0000_1808);
        m_mstatus = 32'h0000_1808;
        idle_check(3);
        line = rand_bits(2);
        csr_write(csr_fields_pkg::MIP, ~(32'd1 << (16 + line)));
        m_pend[line] = 1'b0;
        csr_read(csr_fields_pkg::MIP, rd);
        check_word("mip after single clear", rd, 32'(m_pend) << 16);
        csr_write(csr_fields_pkg::MIP, '0);
        m_pend = '0;
        csr_read(csr_fields_pkg::MIP, rd);
        check_word("mip after full clear", rd, '0);
        csr_write(csr_fields_pkg::MIE, 32'h000F_0000);
        m_mie = '1;
        idle_check(3);
        finish_test("masking");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
